// ==== vlog.f ====
+incdir+include
src/arcade_io_pkg.sv
src/ps2_key_decoder.sv
src/dip_switch_bank.sv
src/control_merge.sv
src/pll_reconfig_seq.sv
src/arcade_io_top.sv
tests/tb_arcade_io.sv

// ==== Makefile ====
# Verilator build and run of the arcade control front end testbench

VERILATOR ?= verilator
TOP       ?= tb_arcade_io
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -j 0

.PHONY: sim clean

# The simulation binary exits non-zero on $fatal
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

// ==== tests/tb_arcade_io.sv ====
// Testbench for the control front end with clock, LCG stimulus, reference model and checks
`timescale 1ns/100ps
`default_nettype none
`include "arcade_io_params.svh"

module tb_arcade_io import arcade_io_pkg::*; ();

	localparam int RESET_CYCLES = 5;
	localparam int LOCK_CYCLES = 10;
	localparam int KEY_EVENTS = 300;
	localparam int MERGE_CYCLES = 300;
	localparam int DIP_WRITES = 200;
	localparam int RECONFIG_RUNS = 8;
	localparam int RECONFIG_CYCLES = 300;
	// Room for waitrequest and unlock stalls in one run
	localparam int STALL_ALLOW = 200;
	localparam int QUIET_CYCLES = 40;
	// Sum of all phases times two
	localparam int CYCLE_LIMIT = 2 * (RESET_CYCLES + LOCK_CYCLES + (KEY_EVENTS + 1)
		+ (MERGE_CYCLES + 1) + 2 * DIP_WRITES
		+ RECONFIG_RUNS * (RECONFIG_CYCLES + STALL_ALLOW));
	localparam int N_PARAM = `ARC_PLL_PARAM_COUNT;

	// The twelve known scan codes
	localparam logic [7:0] KEY_CODES [12] = '{
		8'h16, 8'h1E, 8'h2E, 8'h36, 8'h46, 8'h4D,
		8'h75, 8'h72, 8'h6B, 8'h74, 8'h14, 8'h11
	};
	// Reference copy of the PLL tables
	localparam logic [`ARC_CFG_ADDR_W-1:0] PLL_ADDR [N_PARAM] = '{
		6'h0, 6'h4, 6'h3, 6'h5, 6'h5, 6'h9, 6'h8, 6'h7, 6'h2
	};
	localparam logic [`ARC_CFG_DATA_W-1:0] PLL_DATA_57 [N_PARAM] = '{
		32'h0, 32'h20504, 32'h10000, 32'h505, 32'h60302,
		32'h2, 32'h7, 32'h9999999A, 32'h1
	};
	localparam logic [`ARC_CFG_DATA_W-1:0] PLL_DATA_60 [N_PARAM] = '{
		32'h0, 32'hA0A, 32'h10000, 32'hA0A, 32'h40505,
		32'h2, 32'h7, 32'h0DD3FDC4, 32'h1
	};

	logic MS_CLK = 1'b0;
	logic reset;
	ps2_event_t key;
	ioctl_wr_t ioctl;
	joy_word_t joystick_0;
	joy_word_t joystick_1;
	joy_word_t db15_1;
	joy_word_t db15_2;
	logic [1:0] snac_dev;
	video_timing_t timing_sel;
	logic pll_locked;
	logic cfg_waitrequest;
	player_byte_t player1;
	player_byte_t player2;
	logic pause_req;
	dip_byte_t dsw1;
	dip_byte_t dsw2;
	dip_byte_t game_sel;
	pll_cfg_t cfg;
	logic pll_init_locked;
	logic reconfig_pause;

	// Reference model state
	key_buttons_t m_btn;
	logic pend_valid;
	logic [7:0] pend_code;
	logic pend_pressed;
	dip_byte_t m_dip [`ARC_DIP_COUNT];
	dip_byte_t m_game;
	video_timing_t m_timing;

	logic [31:0] lcg_state = 32'd75;
	int cycle_count = 0;

	arcade_io_top i_arcade_io_top (
		.MS_CLK          (MS_CLK),
		.reset           (reset),
		.key             (key),
		.ioctl           (ioctl),
		.joystick_0      (joystick_0),
		.joystick_1      (joystick_1),
		.db15_1          (db15_1),
		.db15_2          (db15_2),
		.snac_dev        (snac_dev),
		.timing_sel      (timing_sel),
		.pll_locked      (pll_locked),
		.cfg_waitrequest (cfg_waitrequest),
		.player1         (player1),
		.player2         (player2),
		.pause_req       (pause_req),
		.dsw1            (dsw1),
		.dsw2            (dsw2),
		.game_sel        (game_sel),
		.cfg             (cfg),
		.pll_init_locked (pll_init_locked),
		.reconfig_pause  (reconfig_pause)
	);

	// 50 MHz
	always #10 MS_CLK = ~MS_CLK;

	//////////////////////////////////////////////////
	// Failure, timeout and compares
	//////////////////////////////////////////////////

	task automatic stop_run(input string why);
		$display("%s", why);
		$display("Test failed");
		$fatal(1, "simulation stopped on the first error");
	endtask

	always @(posedge MS_CLK) begin
		cycle_count = cycle_count + 1;
		if (cycle_count > CYCLE_LIMIT) begin
			stop_run("Timeout: the run went past its cycle limit");
		end
	end

	task automatic player_cmp(input string name, input player_byte_t got, input player_byte_t exp);
		if (got !== exp) begin
			stop_run($sformatf("ERROR time=%0t signal=%s got=%h expected=%h",
				$time, name, got, exp));
		end
	endtask

	task automatic dip_cmp(input string name, input dip_byte_t got, input dip_byte_t exp);
		if (got !== exp) begin
			stop_run($sformatf("ERROR time=%0t signal=%s got=%h expected=%h",
				$time, name, got, exp));
		end
	endtask

	task automatic cfg_cmp(input string name, input pll_cfg_t got, input pll_cfg_t exp);
		if (got !== exp) begin
			stop_run($sformatf("ERROR time=%0t signal=%s got=%h expected=%h",
				$time, name, got, exp));
		end
	endtask

	task automatic flag_cmp(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			stop_run($sformatf("ERROR time=%0t signal=%s got=%b expected=%b",
				$time, name, got, exp));
		end
	endtask

	//////////////////////////////////////////////////
	// Stimulus helpers
	//////////////////////////////////////////////////

	// Upper half of the LCG is the better half
	function automatic logic [15:0] rand16();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state[31:16];
	endfunction

	task automatic send_key(input logic [7:0] code, input logic pressed, input logic ext);
		key.toggle = ~key.toggle;
		key.pressed = pressed;
		key.extended = ext;
		key.code = code;
		pend_valid = 1'b1;
		pend_code = code;
		pend_pressed = pressed;
	endtask

	// Mostly known codes with a quarter unknown
	task automatic random_key();
		logic [15:0] r;
		logic [7:0] code;
		r = rand16();
		if (r[3:0] < 4'd12) begin
			code = KEY_CODES[r[3:0]];
		end else begin
			code = r[15:8];
		end
		send_key(code, r[4], r[5]);
	endtask

	// Event seen by the decoder at the last rising edge
	task automatic commit_key();
		if (pend_valid) begin
			case (pend_code)
				8'h16: m_btn.start1 = pend_pressed;
				8'h1E: m_btn.start2 = pend_pressed;
				8'h2E: m_btn.coin1 = pend_pressed;
				8'h36: m_btn.coin2 = pend_pressed;
				8'h46: m_btn.service = pend_pressed;
				8'h4D: m_btn.pause = pend_pressed;
				8'h75: m_btn.up = pend_pressed;
				8'h72: m_btn.down = pend_pressed;
				8'h6B: m_btn.left = pend_pressed;
				8'h74: m_btn.right = pend_pressed;
				8'h14: m_btn.btn1 = pend_pressed;
				8'h11: m_btn.btn2 = pend_pressed;
				default: ;
			endcase
			pend_valid = 1'b0;
		end
	endtask

	// One player byte with the top two bits given active high
	function automatic player_byte_t expected_player(joy_word_t db, joy_word_t host,
		logic top, logic next);
		logic right;
		logic left;
		logic down;
		logic up;
		logic b1;
		logic b2;
		right = db[0] | host[0] | m_btn.right;
		left = db[1] | host[1] | m_btn.left;
		down = db[2] | host[2] | m_btn.down;
		up = db[3] | host[3] | m_btn.up;
		b1 = db[4] | host[4] | m_btn.btn1;
		b2 = db[5] | host[5] | m_btn.btn2;
		return ~{top, next, b2, b1, down, up, left, right};
	endfunction

	task automatic check_merge();
		joy_word_t db1;
		joy_word_t db2;
		joy_word_t joy_or;
		logic start1;
		logic start2;
		logic coin1;
		logic coin2;
		logic pause;
		db1 = snac_dev[0] ? db15_1 : 16'h0;
		db2 = snac_dev[1] ? db15_2 : 16'h0;
		joy_or = joystick_0 | joystick_1;
		start1 = db1[10] | m_btn.start1 | joy_or[6];
		start2 = db2[10] | db1[6] | m_btn.start2 | joy_or[8];
		coin1 = db1[11] | m_btn.coin1 | joystick_0[7];
		coin2 = db2[11] | m_btn.coin2 | joystick_1[7];
		pause = (db1[4] & db1[10]) | (db2[4] & db2[10]) | m_btn.pause | joy_or[9];
		player_cmp("player1", player1, expected_player(db1, joystick_0, start2, start1));
		player_cmp("player2", player2, expected_player(db2, joystick_1, coin2, coin1));
		flag_cmp("pause_req", pause_req, pause);
	endtask

	// Random index and then a random address class
	task automatic random_write();
		logic [15:0] r;
		logic [15:0] a_hi;
		r = rand16();
		a_hi = rand16();
		ioctl.wr = 1'b1;
		ioctl.data = r[15:8];
		case (r[1:0])
			2'd0: ioctl.index = 8'(`ARC_DIP_INDEX);
			2'd1: ioctl.index = 8'(`ARC_GAME_INDEX);
			default: ioctl.index = a_hi[7:0];
		endcase
		ioctl.addr = '0;
		case (r[3:2])
			2'd0: ioctl.addr[2:0] = r[6:4];
			2'd1: ioctl.addr[2:0] = 3'd0;
			2'd2: begin
				// Just past the switch block
				ioctl.addr[2:0] = r[6:4];
				ioctl.addr[3] = 1'b1;
			end
			default: ioctl.addr = {a_hi[15:8], r[7:4], a_hi[12:0]};
		endcase
		if (ioctl.index == 8'(`ARC_DIP_INDEX) && ioctl.addr < 25'(`ARC_DIP_COUNT)) begin
			m_dip[ioctl.addr[2:0]] = ioctl.data;
		end
		if (ioctl.index == 8'(`ARC_GAME_INDEX) && ioctl.addr == '0) begin
			m_game = ioctl.data;
		end
	endtask

	function automatic pll_cfg_t expected_write(video_timing_t t, logic [3:0] idx);
		pll_cfg_t w;
		w.write = 1'b1;
		w.addr = PLL_ADDR[idx];
		w.data = (t == VIDEO_60HZ) ? PLL_DATA_60[idx] : PLL_DATA_57[idx];
		return w;
	endfunction

	//////////////////////////////////////////////////
	// PLL reconfiguration under stalls
	//////////////////////////////////////////////////

	task automatic run_reconfig(input video_timing_t sel);
		logic changed;
		logic seen_pause;
		logic done;
		logic first;
		int writes;
		int quiet;
		logic [15:0] r;
		changed = (sel != m_timing);
		seen_pause = 1'b0;
		done = 1'b0;
		first = 1'b1;
		writes = 0;
		quiet = 0;
		if (changed) begin
			m_timing = sel;
		end
		while (!done) begin
			@(negedge MS_CLK);
			if (first) begin
				timing_sel = sel;
				first = 1'b0;
			end
			// Waitrequest a quarter of the time and unlock now and then
			r = rand16();
			cfg_waitrequest = (r[1:0] == 2'b00);
			pll_locked = (r[7:4] != 4'h0);
			#5;
			if (cfg.write) begin
				if (cfg_waitrequest || !pll_locked) begin
					stop_run("PLL write strobe raised while the port was stalled");
				end
				if (!changed || writes >= N_PARAM || !reconfig_pause) begin
					stop_run("PLL write strobe raised outside a reconfiguration");
				end
				cfg_cmp("cfg", cfg, expected_write(m_timing, writes[3:0]));
				writes++;
			end
			if (changed) begin
				if (reconfig_pause) begin
					seen_pause = 1'b1;
				end else if (seen_pause) begin
					if (writes != N_PARAM) begin
						stop_run($sformatf("reconfig_pause fell after %0d of %0d PLL writes",
							writes, N_PARAM));
					end
					done = 1'b1;
				end
			end else begin
				// Nothing may happen on the same timing
				flag_cmp("reconfig_pause", reconfig_pause, 1'b0);
				quiet++;
				if (quiet == QUIET_CYCLES) begin
					done = 1'b1;
				end
			end
		end
	endtask

	//////////////////////////////////////////////////
	// Test sequence
	//////////////////////////////////////////////////

	initial begin
		logic [15:0] r;
		video_timing_t sel;
		reset = 1'b1;
		key = '0;
		ioctl = '0;
		joystick_0 = '0;
		joystick_1 = '0;
		db15_1 = '0;
		db15_2 = '0;
		snac_dev = 2'b00;
		timing_sel = VIDEO_57HZ;
		pll_locked = 1'b0;
		cfg_waitrequest = 1'b1;
		m_btn = '0;
		pend_valid = 1'b0;
		pend_code = '0;
		pend_pressed = 1'b0;
		for (int i = 0; i < `ARC_DIP_COUNT; i++) begin
			m_dip[i] = '0;
		end
		m_game = '0;
		m_timing = VIDEO_57HZ;

		repeat (RESET_CYCLES) @(posedge MS_CLK);
		@(negedge MS_CLK);
		reset = 1'b0;
		#5;
		// Everything idle out of reset
		player_cmp("player1", player1, 8'hFF);
		player_cmp("player2", player2, 8'hFF);
		flag_cmp("pause_req", pause_req, 1'b0);
		dip_cmp("dsw1", dsw1, 8'h00);
		dip_cmp("dsw2", dsw2, 8'h00);
		dip_cmp("game_sel", game_sel, 8'h00);
		flag_cmp("cfg.write", cfg.write, 1'b0);
		flag_cmp("reconfig_pause", reconfig_pause, 1'b0);
		flag_cmp("pll_init_locked", pll_init_locked, 1'b0);

		// Locked behind waitrequest, then free port without lock
		@(negedge MS_CLK);
		pll_locked = 1'b1;
		@(negedge MS_CLK);
		pll_locked = 1'b0;
		cfg_waitrequest = 1'b0;
		#5;
		flag_cmp("pll_init_locked", pll_init_locked, 1'b0);
		@(negedge MS_CLK);
		pll_locked = 1'b1;
		#5;
		flag_cmp("pll_init_locked", pll_init_locked, 1'b0);

		// Lock the PLL and wait for the init flag
		do begin
			@(negedge MS_CLK);
			#5;
		end while (!pll_init_locked);
		flag_cmp("reconfig_pause", reconfig_pause, 1'b0);

		// One key event per cycle with idle pads
		repeat (KEY_EVENTS) begin
			@(negedge MS_CLK);
			commit_key();
			random_key();
			#5;
			check_merge();
		end
		@(negedge MS_CLK);
		commit_key();
		#5;
		check_merge();

		// Random pads and DB15 words with keys now and then
		repeat (MERGE_CYCLES) begin
			@(negedge MS_CLK);
			commit_key();
			r = rand16();
			joystick_0 = rand16();
			joystick_1 = rand16();
			db15_1 = rand16();
			db15_2 = rand16();
			snac_dev = r[1:0];
			if (r[3:2] == 2'b00) begin
				random_key();
			end
			#5;
			check_merge();
		end
		@(negedge MS_CLK);
		commit_key();
		joystick_0 = '0;
		joystick_1 = '0;
		db15_1 = '0;
		db15_2 = '0;
		snac_dev = 2'b00;
		#5;
		check_merge();

		// Download writes checked after each strobe
		repeat (DIP_WRITES) begin
			@(negedge MS_CLK);
			random_write();
			@(negedge MS_CLK);
			ioctl.wr = 1'b0;
			#5;
			dip_cmp("dsw1", dsw1, m_dip[0]);
			dip_cmp("dsw2", dsw2, m_dip[1]);
			dip_cmp("game_sel", game_sel, m_game);
		end

		// Even runs always switch and the last one repeats the latched timing
		for (int i = 0; i < RECONFIG_RUNS; i++) begin
			r = rand16();
			if (i == RECONFIG_RUNS - 1) begin
				sel = m_timing;
			end else if (i[0] == 1'b0) begin
				sel = (m_timing == VIDEO_57HZ) ? VIDEO_60HZ : VIDEO_57HZ;
			end else begin
				sel = video_timing_t'(r[0]);
			end
			run_reconfig(sel);
		end

		flag_cmp("pll_init_locked", pll_init_locked, 1'b1);
		$display("Test passed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== src/arcade_io_top.sv ====
// Control front end top with key decoder, DIP bank, control merge and PLL sequencer
`timescale 1ns/100ps
`default_nettype none

module arcade_io_top import arcade_io_pkg::*; (
	input  logic          MS_CLK,
	input  logic          reset,
	input  ps2_event_t    key,
	input  ioctl_wr_t     ioctl,
	input  joy_word_t     joystick_0,
	input  joy_word_t     joystick_1,
	input  joy_word_t     db15_1,
	input  joy_word_t     db15_2,
	input  logic [1:0]    snac_dev,
	input  video_timing_t timing_sel,
	input  logic          pll_locked,
	input  logic          cfg_waitrequest,
	output player_byte_t  player1,
	output player_byte_t  player2,
	output logic          pause_req,
	output dip_byte_t     dsw1,
	output dip_byte_t     dsw2,
	output dip_byte_t     game_sel,
	output pll_cfg_t      cfg,
	output logic          pll_init_locked,
	output logic          reconfig_pause
);

	// Held keyboard buttons into the merge
	key_buttons_t buttons;

	//////////////////////////////////////////////////
	// Input side
	//////////////////////////////////////////////////

	ps2_key_decoder i_ps2_key_decoder (
		.MS_CLK  (MS_CLK),
		.reset   (reset),
		.key     (key),
		.buttons (buttons)
	);

	// Switch bytes go straight to the board
	dip_switch_bank i_dip_switch_bank (
		.MS_CLK   (MS_CLK),
		.reset    (reset),
		.ioctl    (ioctl),
		.dsw1     (dsw1),
		.dsw2     (dsw2),
		.game_sel (game_sel)
	);

	//////////////////////////////////////////////////
	// Merge and PLL side
	//////////////////////////////////////////////////

	control_merge i_control_merge (
		.buttons    (buttons),
		.joystick_0 (joystick_0),
		.joystick_1 (joystick_1),
		.db15_1     (db15_1),
		.db15_2     (db15_2),
		.snac_dev   (snac_dev),
		.player1    (player1),
		.player2    (player2),
		.pause_req  (pause_req)
	);

	pll_reconfig_seq i_pll_reconfig_seq (
		.MS_CLK          (MS_CLK),
		.reset           (reset),
		.timing_sel      (timing_sel),
		.pll_locked      (pll_locked),
		.cfg_waitrequest (cfg_waitrequest),
		.cfg             (cfg),
		.pll_init_locked (pll_init_locked),
		.reconfig_pause  (reconfig_pause)
	);

endmodule

`default_nettype wire

// ==== src/pll_reconfig_seq.sv ====
// Fractional PLL reconfiguration sequencer with pause counter and 57/60 Hz parameter tables
`timescale 1ns/100ps
`default_nettype none
`include "arcade_io_params.svh"

module pll_reconfig_seq import arcade_io_pkg::*; (
	input  logic          MS_CLK,
	input  logic          reset,
	input  video_timing_t timing_sel,
	input  logic          pll_locked,
	input  logic          cfg_waitrequest,
	output pll_cfg_t      cfg,
	output logic          pll_init_locked,
	output logic          reconfig_pause
);

	localparam int N_PARAM = `ARC_PLL_PARAM_COUNT;
	localparam int IDX_W = $clog2(N_PARAM);
	localparam int CNT_W = $clog2(`ARC_RECONFIG_PAUSE + 1);
	localparam logic [CNT_W-1:0] PAUSE_LAST = `ARC_RECONFIG_PAUSE;

	//////////////////////////////////////////////////
	// Parameter tables
	//////////////////////////////////////////////////

	// Mode, M, N, C0, C1, charge pump, bandwidth, M fraction, start
	localparam logic [`ARC_CFG_ADDR_W-1:0] CFG_ADDR [N_PARAM] = '{
		6'h0, 6'h4, 6'h3, 6'h5, 6'h5, 6'h9, 6'h8, 6'h7, 6'h2
	};
	// 48 MHz family for native timing
	localparam logic [`ARC_CFG_DATA_W-1:0] DATA_57HZ [N_PARAM] = '{
		32'h0, 32'h20504, 32'h10000, 32'h505, 32'h60302,
		32'h2, 32'h7, 32'h9999999A, 32'h1
	};
	// 50.135 MHz family for standard 60 Hz
	localparam logic [`ARC_CFG_DATA_W-1:0] DATA_60HZ [N_PARAM] = '{
		32'h0, 32'hA0A, 32'h10000, 32'hA0A, 32'h40505,
		32'h2, 32'h7, 32'h0DD3FDC4, 32'h1
	};

	reconfig_state_t state;
	video_timing_t timing_lat;
	logic [CNT_W-1:0] pause_cnt;
	logic [IDX_W-1:0] param_idx;
	// Cycle in which the port takes a write
	logic accept;

	assign accept = pll_locked & ~cfg_waitrequest;

	//////////////////////////////////////////////////
	// Sequencer FSM
	//////////////////////////////////////////////////

	always_ff @(posedge MS_CLK) begin
		if (reset) begin
			state <= IDLE;
			timing_lat <= VIDEO_57HZ;
			pause_cnt <= '0;
			param_idx <= '0;
			pll_init_locked <= 1'b0;
			reconfig_pause <= 1'b0;
		end else if (accept) begin
			// Sticky after the first good cycle
			pll_init_locked <= 1'b1;
			case (state)
				IDLE: begin
					if (timing_sel != timing_lat) begin
						timing_lat <= timing_sel;
						pause_cnt <= CNT_W'(1);
						param_idx <= '0;
						reconfig_pause <= 1'b1;
						state <= PAUSE;
					end else begin
						// PLL back in lock, let the core run
						reconfig_pause <= 1'b0;
					end
				end
				PAUSE: begin
					if (pause_cnt == PAUSE_LAST) begin
						state <= WRITE;
					end else begin
						pause_cnt <= pause_cnt + CNT_W'(1);
					end
				end
				WRITE: begin
					// One pair per accepted cycle
					if (param_idx == IDX_W'(N_PARAM - 1)) begin
						param_idx <= '0;
						state <= IDLE;
					end else begin
						param_idx <= param_idx + IDX_W'(1);
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

	// Strobe only when the port can take it
	always_comb begin
		cfg.write = (state == WRITE) && accept;
		cfg.addr = CFG_ADDR[param_idx];
		cfg.data = (timing_lat == VIDEO_60HZ) ? DATA_60HZ[param_idx] : DATA_57HZ[param_idx];
	end

endmodule

`default_nettype wire

// ==== src/control_merge.sv ====
// Keyboard, host joystick and DB15 merge into the active-low player bytes and pause request
`timescale 1ns/100ps
`default_nettype none

module control_merge import arcade_io_pkg::*; (
	input  key_buttons_t buttons,
	input  joy_word_t    joystick_0,
	input  joy_word_t    joystick_1,
	input  joy_word_t    db15_1,
	input  joy_word_t    db15_2,
	input  logic [1:0]   snac_dev,
	output player_byte_t player1,
	output player_byte_t player2,
	output logic         pause_req
);

	// DB15 words after the per-port enable
	joy_word_t db1;
	joy_word_t db2;
	// OR of both host pads, for the shared buttons
	joy_word_t joy_any;
	logic start1_n;
	logic start2_n;
	logic coin1_n;
	logic coin2_n;

	// Active-low {btn2, btn1, down, up, left, right} of one player
	// Host and DB15 words carry up on bit 3, the board wants down there
	function automatic logic [5:0] player_dirs(joy_word_t db, joy_word_t host, key_buttons_t kb);
		logic [5:0] held;
		held = db[5:0] | host[5:0] | {kb.btn2, kb.btn1, kb.up, kb.down, kb.left, kb.right};
		return ~{held[5], held[4], held[2], held[3], held[1], held[0]};
	endfunction

	//////////////////////////////////////////////////
	// Source gating
	//////////////////////////////////////////////////

	assign db1 = snac_dev[0] ? db15_1 : '0;
	assign db2 = snac_dev[1] ? db15_2 : '0;
	assign joy_any = joystick_0 | joystick_1;

	//////////////////////////////////////////////////
	// Shared buttons
	//////////////////////////////////////////////////

	// P1 button C on DB15 doubles as start 2
	assign start1_n = ~(db1[10] | buttons.start1 | joy_any[6]);
	assign start2_n = ~(db2[10] | db1[6] | buttons.start2 | joy_any[8]);
	assign coin1_n = ~(db1[11] | buttons.coin1 | joystick_0[7]);
	assign coin2_n = ~(db2[11] | buttons.coin2 | joystick_1[7]);

	assign player1 = {start2_n, start1_n, player_dirs(db1, joystick_0, buttons)};
	assign player2 = {coin2_n, coin1_n, player_dirs(db2, joystick_1, buttons)};

	// Start+A on a DB15 pad pauses, active high
	assign pause_req = (db1[4] & db1[10]) | (db2[4] & db2[10]) | buttons.pause | joy_any[9];

endmodule

`default_nettype wire

// ==== src/dip_switch_bank.sv ====
// DIP switch and game select capture from the download stream
`timescale 1ns/100ps
`default_nettype none
`include "arcade_io_params.svh"

module dip_switch_bank import arcade_io_pkg::*; (
	input  logic      MS_CLK,
	input  logic      reset,
	input  ioctl_wr_t ioctl,
	output dip_byte_t dsw1,
	output dip_byte_t dsw2,
	output dip_byte_t game_sel
);

	localparam logic [7:0] DIP_INDEX = `ARC_DIP_INDEX;
	localparam logic [7:0] GAME_INDEX = `ARC_GAME_INDEX;
	localparam logic [`ARC_IOCTL_ADDR_W-1:0] DIP_LIMIT = `ARC_DIP_COUNT;
	localparam int SEL_W = $clog2(`ARC_DIP_COUNT);

	// All eight switch bytes, the board reads the first two
	dip_byte_t sw [`ARC_DIP_COUNT];
	logic dip_hit;
	logic game_hit;

	// Decode of the strobed write
	assign dip_hit = ioctl.wr && (ioctl.index == DIP_INDEX) && (ioctl.addr < DIP_LIMIT);
	assign game_hit = ioctl.wr && (ioctl.index == GAME_INDEX) && (ioctl.addr == '0);

	always_ff @(posedge MS_CLK) begin
		if (reset) begin
			for (int i = 0; i < `ARC_DIP_COUNT; i++) begin
				sw[i] <= '0;
			end
			game_sel <= '0;
		end else begin
			// Low address bits pick the byte
			if (dip_hit) begin
				sw[ioctl.addr[SEL_W-1:0]] <= ioctl.data;
			end
			if (game_hit) begin
				game_sel <= ioctl.data;
			end
		end
	end

	assign dsw1 = sw[0];
	assign dsw2 = sw[1];

endmodule

`default_nettype wire

// ==== src/ps2_key_decoder.sv ====
// Keyboard event decoder holding the twelve game button states
`timescale 1ns/100ps
`default_nettype none

module ps2_key_decoder import arcade_io_pkg::*; (
	input  logic         MS_CLK,
	input  logic         reset,
	input  ps2_event_t   key,
	output key_buttons_t buttons
);

	// Toggle seen at the previous edge
	logic prev_toggle;

	//////////////////////////////////////////////////
	// Event detect and button update
	//////////////////////////////////////////////////

	always_ff @(posedge MS_CLK) begin
		if (reset) begin
			// Track the live toggle so a held event is not replayed
			prev_toggle <= key.toggle;
			buttons <= '0;
		end else begin
			prev_toggle <= key.toggle;
			// New event when the toggle flips
			if (key.toggle != prev_toggle) begin
				case (key.code)
					// Start and coin keys 1, 2, 5, 6
					8'h16: buttons.start1 <= key.pressed;
					8'h1E: buttons.start2 <= key.pressed;
					8'h2E: buttons.coin1 <= key.pressed;
					8'h36: buttons.coin2 <= key.pressed;
					// Service on 9, pause on P
					8'h46: buttons.service <= key.pressed;
					8'h4D: buttons.pause <= key.pressed;
					// Cursor keys
					8'h75: buttons.up <= key.pressed;
					8'h72: buttons.down <= key.pressed;
					8'h6B: buttons.left <= key.pressed;
					8'h74: buttons.right <= key.pressed;
					// Ctrl and alt as fire buttons
					8'h14: buttons.btn1 <= key.pressed;
					8'h11: buttons.btn2 <= key.pressed;
					// Unknown codes leave everything as is
					default: ;
				endcase
			end
		end
	end

endmodule

`default_nettype wire

// ==== src/arcade_io_pkg.sv ====
// Joystick, control and switch vectors, key and download structs, PLL port struct and enums
`default_nettype none
`include "arcade_io_params.svh"

package arcade_io_pkg;
	typedef logic [15:0] joy_word_t;
	// Active low, as the game board expects
	typedef logic [7:0] player_byte_t;
	typedef logic [7:0] dip_byte_t;

	// Same bit order as the host keyboard word
	typedef struct packed {
		logic toggle;
		logic pressed;
		logic extended;
		logic [7:0] code;
	} ps2_event_t;

	typedef struct packed {
		logic wr;
		logic [7:0] index;
		logic [`ARC_IOCTL_ADDR_W-1:0] addr;
		logic [7:0] data;
	} ioctl_wr_t;

	// Held keyboard buttons, active high
	typedef struct packed {
		logic up;
		logic down;
		logic left;
		logic right;
		logic btn1;
		logic btn2;
		logic coin1;
		logic coin2;
		logic start1;
		logic start2;
		logic pause;
		logic service;
	} key_buttons_t;

	typedef enum logic {
		VIDEO_57HZ = 1'b0,
		VIDEO_60HZ = 1'b1
	} video_timing_t;

	// Write side of the PLL configuration port
	typedef struct packed {
		logic write;
		logic [`ARC_CFG_ADDR_W-1:0] addr;
		logic [`ARC_CFG_DATA_W-1:0] data;
	} pll_cfg_t;

	typedef enum logic [1:0] {
		IDLE,
		PAUSE,
		WRITE
	} reconfig_state_t;
endpackage

`default_nettype wire

// ==== include/arcade_io_params.svh ====
// Download indexes, DIP and PLL parameter counts, pause length and bus widths
`ifndef ARCADE_IO_PARAMS_SVH
`define ARCADE_IO_PARAMS_SVH

//////////////////////////////////////////////////
// Download stream
//////////////////////////////////////////////////

// Index of the DIP switch block in the download
`define ARC_DIP_INDEX 254
// Index of the game select byte
`define ARC_GAME_INDEX 1
// Eight switch bytes, addresses 0..7
`define ARC_DIP_COUNT 8
`define ARC_IOCTL_ADDR_W 25

//////////////////////////////////////////////////
// PLL reconfiguration
//////////////////////////////////////////////////

// Address/data pairs written per timing change
`define ARC_PLL_PARAM_COUNT 9
// Settle time before the first write, in accepted cycles
`define ARC_RECONFIG_PAUSE 255
`define ARC_CFG_ADDR_W 6
`define ARC_CFG_DATA_W 32

`endif
